/* common/ex_trace_consts.svh */
`ifndef EX_TRACE_CONSTS_SVH
`define EX_TRACE_CONSTS_SVH

// Widths of the trace record fields
`define EXT_ADDR_WIDTH 32
`define EXT_TIME_WIDTH 32
`define EXT_TAG_WIDTH 8

// Number of records queued between decode tracking and the execute tracker
`define EXT_FIFO_DEPTH 4

// Tracked signals, index 0 is ex_ready and index 1 is the data memory request
`define EXT_NUM_TRACKED 2
`define EXT_SIG_EX 0
`define EXT_SIG_MEM 1

`endif

/* common/ex_trace_pkg.sv */
`include "ex_trace_consts.svh"

package ex_trace_pkg;

    // One trace record as it travels from decode tracking to the output
    typedef struct packed {
        logic [`EXT_TAG_WIDTH-1:0]  tag;
        logic                       pass_through;
        logic [`EXT_TIME_WIDTH-1:0] id_time_end;
        logic [`EXT_TIME_WIDTH-1:0] ex_time_start;
        logic [`EXT_TIME_WIDTH-1:0] ex_time_end;
        logic [`EXT_TIME_WIDTH-1:0] mem_time_start;
        logic [`EXT_TIME_WIDTH-1:0] mem_time_end;
        logic [`EXT_ADDR_WIDTH-1:0] mem_addr;
    } trace_rec_t;

    // Result of one signal interval tracker
    // started is set on the first high cycle, done on the first low cycle after the run
    typedef struct packed {
        logic                       started;
        logic                       done;
        logic [`EXT_TIME_WIDTH-1:0] t_start;
        logic [`EXT_TIME_WIDTH-1:0] t_end;
    } interval_t;

endpackage

/* design/ex_trace_tracker.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module ex_trace_tracker
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       id_valid_i,
    input  ex_trace_pkg::trace_rec_t   id_rec_i,
    input  logic                       ex_ready_i,
    input  logic                       data_mem_req_i,
    input  logic                       data_mem_grant_i,
    input  logic [`EXT_ADDR_WIDTH-1:0] data_mem_addr_i,
    output logic                       ex_valid_o,
    output ex_trace_pkg::trace_rec_t   ex_rec_o
);

    logic                             fifo_not_empty;
    logic                             fifo_full;
    ex_trace_pkg::trace_rec_t         fifo_head;
    logic                             pop;
    logic                             arm;
    logic                             start;
    logic                             done;
    ex_trace_pkg::trace_rec_t         start_rec;
    logic [`EXT_TIME_WIDTH-1:0]       timestamp;
    logic [`EXT_NUM_TRACKED-1:0]      tracked_sig;
    ex_trace_pkg::interval_t [`EXT_NUM_TRACKED-1:0] results;

    assign tracked_sig[`EXT_SIG_EX]  = ex_ready_i;
    assign tracked_sig[`EXT_SIG_MEM] = data_mem_req_i;

    trace_fifo i_trace_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wr_i        (id_valid_i),
        .wr_rec_i    (id_rec_i),
        .pop_i       (pop),
        .not_empty_o (fifo_not_empty),
        .full_o      (fifo_full),
        .head_rec_o  (fifo_head)
    );

    ex_stage_sequencer i_ex_stage_sequencer (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .fifo_not_empty_i (fifo_not_empty),
        .fifo_head_i      (fifo_head),
        .done_i           (done),
        .pop_o            (pop),
        .arm_o            (arm),
        .start_o          (start),
        .start_rec_o      (start_rec),
        .timestamp_o      (timestamp)
    );

    // One tracker per monitored signal, all armed together
    for (genvar i = 0; i < `EXT_NUM_TRACKED; i++)
    begin : g_tracker
        signal_interval_tracker i_signal_interval_tracker (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .arm_i       (arm),
            .sig_i       (tracked_sig[i]),
            .timestamp_i (timestamp),
            .result_o    (results[i])
        );
    end

    trace_record_assembler i_trace_record_assembler (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start),
        .start_rec_i (start_rec),
        .results_i   (results),
        .mem_req_i   (data_mem_req_i),
        .mem_grant_i (data_mem_grant_i),
        .mem_addr_i  (data_mem_addr_i),
        .done_o      (done),
        .ex_valid_o  (ex_valid_o),
        .ex_rec_o    (ex_rec_o)
    );

endmodule

/* design/trace_fifo.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module trace_fifo
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    wr_i,
    input  ex_trace_pkg::trace_rec_t wr_rec_i,
    input  logic                    pop_i,
    output logic                    not_empty_o,
    output logic                    full_o,
    output ex_trace_pkg::trace_rec_t head_rec_o
);

    localparam int PTR_W = $clog2(`EXT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`EXT_FIFO_DEPTH + 1);

    ex_trace_pkg::trace_rec_t mem [`EXT_FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_pop;

    assign do_wr  = wr_i && !full_o;
    assign do_pop = pop_i && not_empty_o;

    assign not_empty_o = (count_q != '0);
    assign full_o      = (count_q == CNT_W'(`EXT_FIFO_DEPTH));

    // The head entry is read straight from the array, no read latency
    assign head_rec_o = mem[rd_ptr_q];

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr_q] <= wr_rec_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous write and pop leave the count unchanged
            if (do_wr && !do_pop)
            begin
                count_q <= count_q + 1'b1;
            end
            else if (do_pop && !do_wr)
            begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* ex_tracking/ex_stage_sequencer.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module ex_stage_sequencer
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       fifo_not_empty_i,
    input  ex_trace_pkg::trace_rec_t   fifo_head_i,
    input  logic                       done_i,
    output logic                       pop_o,
    output logic                       arm_o,
    output logic                       start_o,
    output ex_trace_pkg::trace_rec_t   start_rec_o,
    output logic [`EXT_TIME_WIDTH-1:0] timestamp_o
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } seq_state_t;

    seq_state_t                 state_q;
    logic                       take;
    logic [`EXT_TIME_WIDTH-1:0] timestamp_q;

    // A record is taken in the same cycle the FIFO shows one while idle
    assign take = (state_q == ST_IDLE) && fifo_not_empty_i;

    assign pop_o       = take;
    assign arm_o       = take;
    assign start_o     = take;
    assign start_rec_o = fifo_head_i;
    assign timestamp_o = timestamp_q;

    // Local time base, reads 0 in the first cycle after reset is released
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            timestamp_q <= '0;
        end
        else
        begin
            timestamp_q <= timestamp_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (take)
                    begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY:
                begin
                    // Only one record in flight, wait for the assembler to emit it
                    if (done_i)
                    begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

/* ex_tracking/signal_interval_tracker.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module signal_interval_tracker
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       arm_i,
    input  logic                       sig_i,
    input  logic [`EXT_TIME_WIDTH-1:0] timestamp_i,
    output ex_trace_pkg::interval_t    result_o
);

    logic                       armed_q;
    logic                       started_q;
    logic                       done_q;
    logic [`EXT_TIME_WIDTH-1:0] t_start_q;
    logic [`EXT_TIME_WIDTH-1:0] t_end_q;
    logic                       tracking;

    // Live only between arm and the end of the first high run
    assign tracking = armed_q && !done_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            armed_q   <= 1'b0;
            started_q <= 1'b0;
            done_q    <= 1'b0;
        end
        else if (arm_i)
        begin
            armed_q   <= 1'b1;
            started_q <= 1'b0;
            done_q    <= 1'b0;
        end
        else if (tracking)
        begin
            if (sig_i)
            begin
                started_q <= 1'b1;
            end
            else if (started_q)
            begin
                // First low cycle after the run closes the interval
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (arm_i)
        begin
            t_start_q <= '0;
            t_end_q   <= '0;
        end
        else if (tracking && sig_i)
        begin
            if (!started_q)
            begin
                t_start_q <= timestamp_i;
            end
            t_end_q <= timestamp_i;
        end
    end

    assign result_o = '{started: started_q, done: done_q, t_start: t_start_q, t_end: t_end_q};

endmodule

/* ex_tracking/trace_record_assembler.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module trace_record_assembler
(
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  logic                                      start_i,
    input  ex_trace_pkg::trace_rec_t                  start_rec_i,
    input  ex_trace_pkg::interval_t [`EXT_NUM_TRACKED-1:0] results_i,
    input  logic                                      mem_req_i,
    input  logic                                      mem_grant_i,
    input  logic [`EXT_ADDR_WIDTH-1:0]                mem_addr_i,
    output logic                                      done_o,
    output logic                                      ex_valid_o,
    output ex_trace_pkg::trace_rec_t                  ex_rec_o
);

    ex_trace_pkg::trace_rec_t   rec_q;
    ex_trace_pkg::interval_t    ex_res;
    ex_trace_pkg::interval_t    mem_res;
    logic                       busy_q;
    logic                       addr_valid_q;
    logic [`EXT_ADDR_WIDTH-1:0] addr_q;
    logic                       complete;
    logic                       valid_q;

    assign ex_res  = results_i[`EXT_SIG_EX];
    assign mem_res = results_i[`EXT_SIG_MEM];

    // Execute interval closed and the memory access either absent or closed
    assign complete = busy_q && ex_res.done && (!mem_res.started || mem_res.done);

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            busy_q       <= 1'b0;
            valid_q      <= 1'b0;
            addr_valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            if (start_i)
            begin
                addr_valid_q <= 1'b0;
                // Pass-through records leave on the next cycle untouched
                busy_q  <= !start_rec_i.pass_through;
                valid_q <= start_rec_i.pass_through;
            end
            else if (complete)
            begin
                busy_q  <= 1'b0;
                valid_q <= 1'b1;
            end
            else if (busy_q && !addr_valid_q && mem_req_i && mem_grant_i)
            begin
                addr_valid_q <= 1'b1;
            end
        end
    end

    // Payload registers, qualified by the control flags above
    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            rec_q    <= start_rec_i;
            ex_rec_o <= start_rec_i;
        end
        else if (complete)
        begin
            ex_rec_o               <= rec_q;
            ex_rec_o.ex_time_start <= ex_res.t_start;
            ex_rec_o.ex_time_end   <= ex_res.t_end;
            ex_rec_o.mem_time_start <= mem_res.started ? mem_res.t_start : '0;
            ex_rec_o.mem_time_end   <= mem_res.started ? mem_res.t_end : '0;
            ex_rec_o.mem_addr       <= addr_valid_q ? addr_q : '0;
        end
        if (busy_q && !addr_valid_q && mem_req_i && mem_grant_i)
        begin
            addr_q <= mem_addr_i;
        end
    end

    assign ex_valid_o = valid_q;
    assign done_o     = valid_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the execute trace tracker testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f \
    --top-module tb_ex_trace_tracker -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"

/* sources.f */
+incdir+common
common/ex_trace_pkg.sv
design/trace_fifo.sv
ex_tracking/ex_stage_sequencer.sv
ex_tracking/signal_interval_tracker.sv
ex_tracking/trace_record_assembler.sv
design/ex_trace_tracker.sv
testbench/tb_clock_gen.sv
testbench/ex_trace_asserts.sv
testbench/tb_ex_trace_tracker.sv

/* testbench/ex_trace_asserts.sv */
`timescale 1ns/1ps

module ex_trace_asserts
(
    input logic clk,
    input logic rst_n_i,
    input logic id_valid_i,
    input logic fifo_full_i,
    input logic ex_valid_i
);

    // Upstream decode tracking has to hold back while the queue is full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(id_valid_i && fifo_full_i))
        else $error("Trace record written while the FIFO is full");

    // Only one record is in flight, so two outputs can never be adjacent
    a_valid_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_valid_i |=> !ex_valid_i)
        else $error("ex_valid_o high on two consecutive cycles");

    a_valid_low_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> !ex_valid_i)
        else $error("ex_valid_o high while reset is applied");

endmodule

bind ex_trace_tracker ex_trace_asserts i_ex_trace_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .id_valid_i  (id_valid_i),
    .fifo_full_i (fifo_full),
    .ex_valid_i  (ex_valid_o)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released just after a rising edge, like the other stimulus
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* testbench/tb_ex_trace_tracker.sv */
`timescale 1ns/1ps
`include "ex_trace_consts.svh"

module tb_ex_trace_tracker;

    localparam int CLK_PERIOD     = 8;
    localparam int BURST_LEN      = 20;
    localparam int NUM_RECORDS    = 7 + BURST_LEN;
    localparam int MAX_REC_CYCLES = 30;
    localparam int TIMEOUT_CYCLES = NUM_RECORDS * MAX_REC_CYCLES + 100;

    logic                       clk;
    logic                       rst_n_i;
    logic                       id_valid_i;
    ex_trace_pkg::trace_rec_t   id_rec_i;
    logic                       ex_ready_i;
    logic                       data_mem_req_i;
    logic                       data_mem_grant_i;
    logic [`EXT_ADDR_WIDTH-1:0] data_mem_addr_i;
    logic                       ex_valid_o;
    ex_trace_pkg::trace_rec_t   ex_rec_o;

    int                         seed;
    int                         wr_count;
    int                         out_count;
    logic [`EXT_TIME_WIDTH-1:0] tb_time;

    // Per record bookkeeping indexed in write order
    ex_trace_pkg::trace_rec_t   in_rec    [NUM_RECORDS];
    ex_trace_pkg::trace_rec_t   exp_rec   [NUM_RECORDS];
    logic                       exp_known [NUM_RECORDS];
    logic                       exp_timed [NUM_RECORDS];
    logic [`EXT_TIME_WIDTH-1:0] exp_cycle [NUM_RECORDS];
    logic [`EXT_TIME_WIDTH-1:0] wr_time   [NUM_RECORDS];

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(16)) i_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    ex_trace_tracker i_ex_trace_tracker (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .id_valid_i       (id_valid_i),
        .id_rec_i         (id_rec_i),
        .ex_ready_i       (ex_ready_i),
        .data_mem_req_i   (data_mem_req_i),
        .data_mem_grant_i (data_mem_grant_i),
        .data_mem_addr_i  (data_mem_addr_i),
        .ex_valid_o       (ex_valid_o),
        .ex_rec_o         (ex_rec_o)
    );

    // Mirror of the DUT time base that reads 0 in the first cycle after reset release
    always @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            tb_time <= '0;
        end
        else
        begin
            tb_time <= tb_time + 1'b1;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want)
        begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                     name, got, want));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Tracked records take their times and address from the planned activity
    function automatic ex_trace_pkg::trace_rec_t expected_record(
        input ex_trace_pkg::trace_rec_t   rec,
        input logic [`EXT_TIME_WIDTH-1:0] ex_start,
        input logic [`EXT_TIME_WIDTH-1:0] ex_end,
        input logic                       mem_used,
        input logic [`EXT_TIME_WIDTH-1:0] mem_start,
        input logic [`EXT_TIME_WIDTH-1:0] mem_end,
        input logic [`EXT_ADDR_WIDTH-1:0] addr
    );
        ex_trace_pkg::trace_rec_t res;
        res = rec;
        if (!rec.pass_through)
        begin
            res.ex_time_start  = ex_start;
            res.ex_time_end    = ex_end;
            res.mem_time_start = mem_used ? mem_start : '0;
            res.mem_time_end   = mem_used ? mem_end : '0;
            res.mem_addr       = mem_used ? addr : '0;
        end
        return res;
    endfunction

    task automatic compare_record(input int idx);
        ex_trace_pkg::trace_rec_t want;
        want = exp_rec[idx];
        check_value("ex_rec_o.tag", 64'(ex_rec_o.tag), 64'(want.tag));
        check_value("ex_rec_o.pass_through", 64'(ex_rec_o.pass_through),
                    64'(want.pass_through));
        check_value("ex_rec_o.id_time_end", 64'(ex_rec_o.id_time_end), 64'(want.id_time_end));
        check_value("ex_rec_o.ex_time_start", 64'(ex_rec_o.ex_time_start),
                    64'(want.ex_time_start));
        check_value("ex_rec_o.ex_time_end", 64'(ex_rec_o.ex_time_end), 64'(want.ex_time_end));
        check_value("ex_rec_o.mem_time_start", 64'(ex_rec_o.mem_time_start),
                    64'(want.mem_time_start));
        check_value("ex_rec_o.mem_time_end", 64'(ex_rec_o.mem_time_end),
                    64'(want.mem_time_end));
        check_value("ex_rec_o.mem_addr", 64'(ex_rec_o.mem_addr), 64'(want.mem_addr));
        if (exp_timed[idx])
        begin
            check_value("ex_valid_o cycle", 64'(tb_time), 64'(exp_cycle[idx]));
        end
    endtask

    // Outputs are sampled mid-cycle away from the driving edge
    always @(negedge clk)
    begin
        if (rst_n_i && ex_valid_o)
        begin
            if (out_count >= wr_count)
            begin
                report_failure("An output appeared with no record left to match it");
            end
            else if (!exp_known[out_count])
            begin
                report_failure("An output appeared before its activity was driven");
            end
            else
            begin
                compare_record(out_count);
                out_count = out_count + 1;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure("Timeout: an expected output never appeared");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic make_record(input logic pass, output ex_trace_pkg::trace_rec_t rec);
        rec.tag            = 8'($random(seed));
        rec.pass_through   = pass;
        rec.id_time_end    = $random(seed);
        rec.ex_time_start  = $random(seed);
        rec.ex_time_end    = $random(seed);
        rec.mem_time_start = $random(seed);
        rec.mem_time_end   = $random(seed);
        rec.mem_addr       = $random(seed);
    endtask

    task automatic write_record(input ex_trace_pkg::trace_rec_t rec, input logic timed,
                                output int idx);
        idx = wr_count;
        in_rec[idx]    = rec;
        wr_time[idx]   = tb_time;
        exp_known[idx] = 1'b0;
        exp_timed[idx] = 1'b0;
        if (rec.pass_through)
        begin
            exp_rec[idx]   = rec;
            exp_cycle[idx] = tb_time + 2;
            exp_timed[idx] = timed;
            exp_known[idx] = 1'b1;
        end
        wr_count   = wr_count + 1;
        id_valid_i = 1'b1;
        id_rec_i   = rec;
        next_cycle();
        id_valid_i = 1'b0;
    endtask

    task automatic wait_for_output(input int idx);
        while (out_count <= idx)
        begin
            next_cycle();
        end
    endtask

    // Drives one ex_ready run and optionally a memory request that ends in its grant
    task automatic track_record(input int idx, input int ex_len, input logic use_mem,
                                input int mem_delay, input int grant_wait,
                                input logic [`EXT_ADDR_WIDTH-1:0] addr);
        int                         k;
        int                         total;
        logic [`EXT_TIME_WIDTH-1:0] s;
        logic [`EXT_TIME_WIDTH-1:0] ex_e;
        logic [`EXT_TIME_WIDTH-1:0] mem_s;
        logic [`EXT_TIME_WIDTH-1:0] mem_e;
        if (idx > 0)
        begin
            wait_for_output(idx - 1);
            repeat (2) next_cycle();
        end
        while (tb_time < wr_time[idx] + 3)
        begin
            next_cycle();
        end
        s     = tb_time;
        ex_e  = s + ex_len - 1;
        mem_s = s + mem_delay;
        mem_e = mem_s + grant_wait;
        exp_rec[idx]   = expected_record(in_rec[idx], s, ex_e, use_mem, mem_s, mem_e, addr);
        exp_cycle[idx] = ((use_mem && mem_e > ex_e) ? mem_e : ex_e) + 3;
        exp_timed[idx] = 1'b1;
        exp_known[idx] = 1'b1;
        total = ex_len;
        if (use_mem && mem_delay + grant_wait + 1 > total)
        begin
            total = mem_delay + grant_wait + 1;
        end
        for (k = 0; k < total; k++)
        begin
            ex_ready_i       = (k < ex_len);
            data_mem_req_i   = use_mem && (k >= mem_delay) && (k <= mem_delay + grant_wait);
            data_mem_grant_i = use_mem && (k == mem_delay + grant_wait);
            data_mem_addr_i  = data_mem_grant_i ? addr : $random(seed);
            next_cycle();
        end
        ex_ready_i       = 1'b0;
        data_mem_req_i   = 1'b0;
        data_mem_grant_i = 1'b0;
    endtask

    task automatic track_random(input int idx);
        int ex_len;
        ex_len = 1 + rand_below(6);
        track_record(idx, ex_len, rand_below(2) == 1, rand_below(ex_len), rand_below(4),
                     $random(seed));
    endtask

    initial
    begin
        ex_trace_pkg::trace_rec_t rec;
        int                       idx;
        int                       first;
        int                       i;
        seed             = 12982;
        wr_count         = 0;
        out_count        = 0;
        id_valid_i       = 1'b0;
        id_rec_i         = '0;
        ex_ready_i       = 1'b0;
        data_mem_req_i   = 1'b0;
        data_mem_grant_i = 1'b0;
        data_mem_addr_i  = '0;
        wait (rst_n_i === 1'b1);
        next_cycle();

        // Pass-through record into an idle tracker
        make_record(1'b1, rec);
        write_record(rec, 1'b1, idx);
        wait_for_output(idx);

        // Single-cycle execute with no memory access
        make_record(1'b0, rec);
        write_record(rec, 1'b0, idx);
        track_record(idx, 1, 1'b0, 0, 0, '0);
        wait_for_output(idx);

        // Longer execute with a granted memory request
        make_record(1'b0, rec);
        write_record(rec, 1'b0, idx);
        track_record(idx, 4, 1'b1, 1, 1 + rand_below(4), $random(seed));
        wait_for_output(idx);

        // Four records back to back that alternate pass-through and tracked
        first = wr_count;
        for (i = 0; i < 4; i++)
        begin
            make_record(i % 2 == 0, rec);
            write_record(rec, i == 0, idx);
        end
        for (i = 1; i < 4; i += 2)
        begin
            track_random(first + i);
        end
        wait_for_output(wr_count - 1);

        for (i = 0; i < BURST_LEN; i++)
        begin
            make_record(rand_below(4) == 0, rec);
            write_record(rec, 1'b0, idx);
            if (!rec.pass_through)
            begin
                track_random(idx);
            end
            repeat (1 + rand_below(3)) next_cycle();
        end
        wait_for_output(wr_count - 1);

        // A few idle cycles so that a surplus output still reaches the comparator
        repeat (5) next_cycle();

        $display("TEST PASS");
        $finish;
    end

endmodule
